// ==== source/board_pkg.sv ====
package board_pkg;

    // Player ports on the board
    localparam int num_players = 4;

    // Raw board stick: right, left, down, up in 3..0, buttons above
    typedef logic [15:0] board_joy_t;

    // Stick as seen by the game core
    typedef logic [9:0] game_joy_t;

    typedef logic [3:0] dir_t;          // Direction nibble

    // One bit per player for coin, start and pause
    typedef logic [num_players-1:0] player_vec_t;

    typedef logic [3:0] gfx_mask_t;     // Graphics layer enables

    // Start button sits right after the game buttons
    function automatic int start_bit(input int buttons);
        return 6 + (buttons - 2);
    endfunction

    function automatic int coin_bit(input int buttons);
        return 7 + (buttons - 2);
    endfunction

    // Pause is the last button in the board vector
    function automatic int pause_bit(input int buttons);
        return 8 + (buttons - 2);
    endfunction

endpackage

// ==== source/joy_4way_filter.sv ====
`timescale 1ns/100ps

module joy_4way_filter (
    input  logic            clk_sys,
    input  logic            rst,
    input  logic            enable,
    input  board_pkg::dir_t dir_in,
    output board_pkg::dir_t dir_out
);
    import board_pkg::*;

    dir_t last_dir;     // Last single direction seen
    dir_t lowest_dir;
    logic single;
    logic keep_last;

    // Exactly one bit set
    assign single = (dir_in != 4'd0) && ((dir_in & (dir_in - 4'd1)) == 4'd0);

    // Isolate lowest pressed bit
    assign lowest_dir = dir_in & (~dir_in + 4'd1);

    assign keep_last = |(dir_in & last_dir);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out  <= '0;
            last_dir <= '0;
        end else if (!enable) begin
            dir_out <= dir_in;      // 8-way pass through
        end else begin
            if (single) begin
                dir_out  <= dir_in;
                last_dir <= dir_in;
            end else if (dir_in == 4'd0) begin
                dir_out <= '0;
            end else if (keep_last) begin
                // Diagonal, hold on to the earlier direction
                dir_out <= last_dir;
            end else begin
                dir_out <= lowest_dir;
            end
        end
    end

endmodule

// ==== source/joy_capture.sv ====
`timescale 1ns/100ps

module joy_capture #(
    parameter int buttons = 2
) (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  four_way,
    input  board_pkg::board_joy_t joy_board_1,
    input  board_pkg::board_joy_t joy_board_2,
    input  board_pkg::board_joy_t joy_board_3,
    input  board_pkg::board_joy_t joy_board_4,
    output board_pkg::board_joy_t joy_sync_1,
    output board_pkg::board_joy_t joy_sync_2,
    output board_pkg::board_joy_t joy_sync_3,
    output board_pkg::board_joy_t joy_sync_4,
    output logic                  joy_pause
);
    import board_pkg::*;

    localparam int pause_pos = pause_bit(buttons);
    localparam int joy_w     = $bits(board_joy_t);

    board_joy_t       raw_in   [num_players];
    board_joy_t       raw_q    [num_players];   // Sync stage
    logic [joy_w-1:4] btn_q    [num_players];   // Buttons, matched to filter delay
    dir_t             dir_f    [num_players];
    board_joy_t       sync_out [num_players];

    assign raw_in[0] = joy_board_1;
    assign raw_in[1] = joy_board_2;
    assign raw_in[2] = joy_board_3;
    assign raw_in[3] = joy_board_4;

    always_ff @(posedge clk_sys) begin
        for (int p = 0; p < num_players; p++) begin
            raw_q[p] <= raw_in[p];
            btn_q[p] <= raw_q[p][joy_w-1:4];
        end
    end

    for (genvar p = 0; p < num_players; p++) begin : g_player
        joy_4way_filter u_filter (
            .clk_sys ( clk_sys        ),
            .rst     ( rst            ),
            .enable  ( four_way       ),
            .dir_in  ( raw_q[p][3:0]  ),
            .dir_out ( dir_f[p]       )
        );

        assign sync_out[p] = {btn_q[p], dir_f[p]};
    end

    assign joy_sync_1 = sync_out[0];
    assign joy_sync_2 = sync_out[1];
    assign joy_sync_3 = sync_out[2];
    assign joy_sync_4 = sync_out[3];

    // Only players 1 and 2 can pause
    assign joy_pause = sync_out[0][pause_pos] | sync_out[1][pause_pos];

endmodule

// ==== source/game_input_map.sv ====
`timescale 1ns/100ps

module game_input_map #(
    parameter int buttons           = 2,
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic                   rotate,
    input  board_pkg::board_joy_t  joy_sync_1,
    input  board_pkg::board_joy_t  joy_sync_2,
    input  board_pkg::board_joy_t  joy_sync_3,
    input  board_pkg::board_joy_t  joy_sync_4,
    input  board_pkg::game_joy_t   key_joy_1,
    input  board_pkg::game_joy_t   key_joy_2,
    input  board_pkg::game_joy_t   key_joy_3,
    input  board_pkg::player_vec_t key_coin,
    input  board_pkg::player_vec_t key_start,
    output board_pkg::game_joy_t   game_joystick_1,
    output board_pkg::game_joy_t   game_joystick_2,
    output board_pkg::game_joy_t   game_joystick_3,
    output board_pkg::game_joy_t   game_joystick_4,
    output board_pkg::player_vec_t game_coin,
    output board_pkg::player_vec_t game_start
);
    import board_pkg::*;

    localparam int          coin_pos  = coin_bit(buttons);
    localparam int          start_pos = start_bit(buttons);
    localparam game_joy_t   joy_inv   = {$bits(game_joy_t){inputs_active_low}};
    localparam player_vec_t vec_inv   = {num_players{inputs_active_low}};

    board_joy_t  joy     [num_players];
    game_joy_t   key_joy [num_players];
    game_joy_t   merged  [num_players];
    game_joy_t   joy_q   [num_players];
    player_vec_t coin_raw;
    player_vec_t start_raw;

    // Swap direction bits for a rotated screen
    function automatic game_joy_t apply_rotation(input game_joy_t j, input logic rot);
        return rot ? {j[9:4], j[0], j[1], j[3], j[2]} : j;
    endfunction

    assign joy[0] = joy_sync_1;
    assign joy[1] = joy_sync_2;
    assign joy[2] = joy_sync_3;
    assign joy[3] = joy_sync_4;

    assign key_joy[0] = key_joy_1;
    assign key_joy[1] = key_joy_2;
    assign key_joy[2] = key_joy_3;
    assign key_joy[3] = '0;         // No keyboard map for player 4

    always_comb begin
        for (int p = 0; p < num_players; p++) begin
            merged[p]    = apply_rotation(joy[p][9:0] | key_joy[p], rotate);
            coin_raw[p]  = joy[p][coin_pos];
            start_raw[p] = joy[p][start_pos];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            for (int p = 0; p < num_players; p++) begin
                joy_q[p] <= joy_inv;    // Idle level
            end
            game_coin  <= vec_inv;
            game_start <= vec_inv;
        end else begin
            for (int p = 0; p < num_players; p++) begin
                joy_q[p] <= merged[p] ^ joy_inv;
            end
            game_coin  <= (coin_raw | key_coin) ^ vec_inv;
            game_start <= (start_raw | key_start) ^ vec_inv;
        end
    end

    assign game_joystick_1 = joy_q[0];
    assign game_joystick_2 = joy_q[1];
    assign game_joystick_3 = joy_q[2];
    assign game_joystick_4 = joy_q[3];

endmodule

// ==== source/board_control.sv ====
`timescale 1ns/100ps

module board_control #(
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                 clk_sys,
    input  logic                 rst,
    input  logic                 key_pause,
    input  logic                 key_reset,
    input  logic                 key_service,
    input  board_pkg::gfx_mask_t key_gfx,
    input  logic                 joy_pause,
    input  logic                 osd_pause,
    input  logic                 downloading,
    output logic                 game_pause,
    output logic                 soft_rst,
    output logic                 game_service,
    output board_pkg::gfx_mask_t gfx_en
);
    import board_pkg::*;

    logic      pause_r;
    logic      pause_q;
    logic      reset_r;
    logic      reset_q;
    logic      joy_pause_q;
    gfx_mask_t gfx_r;
    gfx_mask_t gfx_q;
    gfx_mask_t gfx_rise;
    logic      pause_hit;

    // Any source toggles once, even if several coincide
    assign pause_hit = (pause_r & ~pause_q) | (joy_pause & ~joy_pause_q) | osd_pause;
    assign gfx_rise  = gfx_r & ~gfx_q;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            pause_r      <= 1'b0;
            pause_q      <= 1'b0;
            reset_r      <= 1'b0;
            reset_q      <= 1'b0;
            joy_pause_q  <= 1'b0;
            gfx_r        <= '0;
            gfx_q        <= '0;
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            game_service <= inputs_active_low;
            gfx_en       <= '1;     // All layers on
        end else begin
            pause_r     <= key_pause;
            pause_q     <= pause_r;
            reset_r     <= key_reset;
            reset_q     <= reset_r;
            joy_pause_q <= joy_pause;
            gfx_r       <= key_gfx;
            gfx_q       <= gfx_r;

            soft_rst     <= reset_r & ~reset_q;     // One cycle per press
            gfx_en       <= gfx_en ^ gfx_rise;
            game_service <= key_service ^ inputs_active_low;

            if (downloading) begin
                game_pause <= 1'b0;     // Never paused while loading
            end else if (pause_hit) begin
                game_pause <= ~game_pause;
            end
        end
    end

endmodule

// ==== source/board_inputs.sv ====
`timescale 1ns/100ps

module board_inputs #(
    parameter int buttons           = 2,
    parameter bit inputs_active_low = 1'b1
) (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  board_pkg::board_joy_t  joy_board_1,
    input  board_pkg::board_joy_t  joy_board_2,
    input  board_pkg::board_joy_t  joy_board_3,
    input  board_pkg::board_joy_t  joy_board_4,
    input  logic                   four_way,
    input  logic                   rotate,
    input  board_pkg::game_joy_t   key_joy_1,
    input  board_pkg::game_joy_t   key_joy_2,
    input  board_pkg::game_joy_t   key_joy_3,
    input  board_pkg::player_vec_t key_coin,
    input  board_pkg::player_vec_t key_start,
    input  logic                   key_pause,
    input  logic                   key_reset,
    input  logic                   key_service,
    input  board_pkg::gfx_mask_t   key_gfx,
    input  logic                   osd_pause,
    input  logic                   downloading,
    output board_pkg::game_joy_t   game_joystick_1,
    output board_pkg::game_joy_t   game_joystick_2,
    output board_pkg::game_joy_t   game_joystick_3,
    output board_pkg::game_joy_t   game_joystick_4,
    output board_pkg::player_vec_t game_coin,
    output board_pkg::player_vec_t game_start,
    output logic                   game_service,
    output logic                   game_pause,
    output logic                   soft_rst,
    output board_pkg::gfx_mask_t   gfx_en
);
    import board_pkg::*;

    board_joy_t joy_sync_1;
    board_joy_t joy_sync_2;
    board_joy_t joy_sync_3;
    board_joy_t joy_sync_4;
    logic       joy_pause;      // Players 1 and 2 pause buttons

    joy_capture #(
        .buttons ( buttons )
    ) u_capture (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .four_way    ( four_way    ),
        .joy_board_1 ( joy_board_1 ),
        .joy_board_2 ( joy_board_2 ),
        .joy_board_3 ( joy_board_3 ),
        .joy_board_4 ( joy_board_4 ),
        .joy_sync_1  ( joy_sync_1  ),
        .joy_sync_2  ( joy_sync_2  ),
        .joy_sync_3  ( joy_sync_3  ),
        .joy_sync_4  ( joy_sync_4  ),
        .joy_pause   ( joy_pause   )
    );

    game_input_map #(
        .buttons           ( buttons           ),
        .inputs_active_low ( inputs_active_low )
    ) u_map (
        .clk_sys         ( clk_sys         ),
        .rst             ( rst             ),
        .rotate          ( rotate          ),
        .joy_sync_1      ( joy_sync_1      ),
        .joy_sync_2      ( joy_sync_2      ),
        .joy_sync_3      ( joy_sync_3      ),
        .joy_sync_4      ( joy_sync_4      ),
        .key_joy_1       ( key_joy_1       ),
        .key_joy_2       ( key_joy_2       ),
        .key_joy_3       ( key_joy_3       ),
        .key_coin        ( key_coin        ),
        .key_start       ( key_start       ),
        .game_joystick_1 ( game_joystick_1 ),
        .game_joystick_2 ( game_joystick_2 ),
        .game_joystick_3 ( game_joystick_3 ),
        .game_joystick_4 ( game_joystick_4 ),
        .game_coin       ( game_coin       ),
        .game_start      ( game_start      )
    );

    board_control #(
        .inputs_active_low ( inputs_active_low )
    ) u_control (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .key_pause    ( key_pause    ),
        .key_reset    ( key_reset    ),
        .key_service  ( key_service  ),
        .key_gfx      ( key_gfx      ),
        .joy_pause    ( joy_pause    ),
        .osd_pause    ( osd_pause    ),
        .downloading  ( downloading  ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .game_service ( game_service ),
        .gfx_en       ( gfx_en       )
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock (
    output logic clk_sys,
    output logic rst
);
    localparam int reset_cycles = 16;

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;      // 10 ns period
    end

    // Reset released on a falling edge, like the other DUT inputs
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
    end

endmodule

// ==== verification/board_inputs_tb.sv ====
`timescale 1ns/100ps

module board_inputs_tb;
    import board_pkg::*;

    // One stimulus step with its expected game side values
    typedef struct packed {
        board_joy_t [3:0]  joy;
        logic              four_way;
        logic              rotate;
        game_joy_t [2:0]   kjoy;
        player_vec_t       kcoin;
        player_vec_t       kstart;
        logic              kpause;
        logic              kreset;
        logic              kservice;
        gfx_mask_t         kgfx;
        logic              osd;
        logic              dl;
        logic [15:0]       hold;
        dir_t [3:0]        filt;        // Direction after the 4-way filter
        game_joy_t [3:0]   ejoy;
        player_vec_t       ecoin;
        player_vec_t       estart;
    } row_t;

    logic        clk_sys;
    logic        rst;
    board_joy_t  joy_board_1;
    board_joy_t  joy_board_2;
    board_joy_t  joy_board_3;
    board_joy_t  joy_board_4;
    logic        four_way;
    logic        rotate;
    game_joy_t   key_joy_1;
    game_joy_t   key_joy_2;
    game_joy_t   key_joy_3;
    player_vec_t key_coin;
    player_vec_t key_start;
    logic        key_pause;
    logic        key_reset;
    logic        key_service;
    gfx_mask_t   key_gfx;
    logic        osd_pause;
    logic        downloading;
    game_joy_t   game_joystick_1;
    game_joy_t   game_joystick_2;
    game_joy_t   game_joystick_3;
    game_joy_t   game_joystick_4;
    player_vec_t game_coin;
    player_vec_t game_start;
    logic        game_service;
    logic        game_pause;
    logic        soft_rst;
    gfx_mask_t   gfx_en;

    row_t        rows [$];
    row_t        r;                     // Row under construction
    row_t        prev;                  // Last applied row
    logic [31:0] lcg_state     = 32'd21;
    int          hold_total    = 0;
    int          timeout_limit = 0;
    int          cycles        = 0;
    int          soft_count    = 0;

    // Reference model of the control state
    logic        exp_pause   = 1'b0;
    gfx_mask_t   exp_gfx     = '1;
    logic        exp_service = 1'b1;
    int          exp_resets  = 0;

    tb_clock u_clock (
        .clk_sys ( clk_sys ),
        .rst     ( rst     )
    );

    board_inputs dut (.*);

    always @(posedge clk_sys) begin
        cycles++;
        if (soft_rst === 1'b1) soft_count++;
        if (cycles > timeout_limit) begin
            abort_run($sformatf("Test timed out after %0d cycles", cycles));
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_joy(input string name, input game_joy_t got, input game_joy_t exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_vec(input string name, input player_vec_t got, input player_vec_t exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_gfx(input string name, input gfx_mask_t got, input gfx_mask_t exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) abort_run($sformatf("MISMATCH %s: got %h expected %h", name, got, exp));
    endtask

    // LCG step keeping only game buttons and bit 9
    function automatic board_joy_t next_buttons();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16] & 16'h0230;
    endfunction

    // Merge, rotate and invert as the game should see it
    function automatic row_t expected_of(input row_t x);
        game_joy_t v;
        game_joy_t w;
        for (int p = 0; p < num_players; p++) begin
            v = {x.joy[p][9:4], x.filt[p]};
            if (p < 3) v = v | x.kjoy[p];       // Player 4 has no keys
            w = v;
            if (x.rotate) begin
                w[3] = v[0];
                w[2] = v[1];
                w[1] = v[3];
                w[0] = v[2];
            end
            x.ejoy[p]   = ~w;
            x.ecoin[p]  = ~(x.joy[p][7] | x.kcoin[p]);
            x.estart[p] = ~(x.joy[p][6] | x.kstart[p]);
        end
        return x;
    endfunction

    task automatic clear_row();
        r      = '0;
        r.hold = 16'd5;
    endtask

    task automatic set_dir(input int p, input dir_t d, input dir_t f);
        r.joy[p][3:0] = d;
        r.filt[p]     = f;
    endtask

    task automatic set_all_dirs(input dir_t d, input dir_t f);
        for (int p = 0; p < num_players; p++) set_dir(p, d, f);
    endtask

    task automatic push_row();
        rows.push_back(expected_of(r));
        hold_total += r.hold;
    endtask

    task automatic build_table();
        // Direction mapping with buttons and keys and alternating rotation
        for (int i = 0; i < 6; i++) begin
            clear_row();
            r.rotate = i[0];
            r.kjoy[i % 3] = game_joy_t'(1) << (i + 2);
            for (int p = 0; p < num_players; p++) begin
                set_dir(p, dir_t'(1) << ((p + i) % 4), dir_t'(1) << ((p + i) % 4));
                r.joy[p] = r.joy[p] | next_buttons();
            end
            push_row();
        end
        // 4-way filter
        clear_row();
        r.four_way = 1'b1;
        set_all_dirs(4'b0100, 4'b0100);     // Down remembered
        push_row();
        set_all_dirs(4'b0101, 4'b0100);     // Keeps down over the lower bit
        push_row();
        set_all_dirs(4'b1010, 4'b0010);     // Falls back to lowest bit
        push_row();
        set_all_dirs(4'b1000, 4'b1000);
        push_row();
        set_all_dirs(4'b1100, 4'b1000);
        push_row();
        set_all_dirs(4'b0000, 4'b0000);
        push_row();
        r.four_way = 1'b0;
        set_all_dirs(4'b1001, 4'b1001);     // 8-way passes the diagonal
        push_row();
        // Coin and start from board buttons and keys
        for (int p = 0; p < num_players; p++) begin
            clear_row();
            r.joy[p][7] = 1'b1;
            r.joy[(p + 1) % 4][6] = 1'b1;
            r.kcoin[(p + 2) % 4] = 1'b1;
            r.kstart[(p + 3) % 4] = 1'b1;
            push_row();
        end
        // Pause sources
        clear_row();
        r.kpause = 1'b1;
        push_row();
        r.hold = 16'd12;                    // Held longer without a second toggle
        push_row();
        clear_row();
        push_row();
        r.joy[1][8] = 1'b1;                 // Player 2 pause button
        push_row();
        clear_row();
        push_row();
        r.osd = 1'b1;
        push_row();
        clear_row();
        r.dl = 1'b1;
        r.kpause = 1'b1;
        push_row();
        clear_row();
        push_row();
        // Soft reset, graphics layers and service
        r.kreset = 1'b1;
        r.kgfx = 4'b0001;
        r.kservice = 1'b1;
        push_row();
        r.hold = 16'd8;
        r.kgfx = 4'b0011;
        r.kservice = 1'b0;
        push_row();
        clear_row();
        push_row();
        r.kreset = 1'b1;
        r.kgfx = 4'b1100;
        r.kservice = 1'b1;
        push_row();
        clear_row();
        push_row();
    endtask

    task automatic drive_inputs(input row_t x);
        joy_board_1 = x.joy[0];
        joy_board_2 = x.joy[1];
        joy_board_3 = x.joy[2];
        joy_board_4 = x.joy[3];
        four_way    = x.four_way;
        rotate      = x.rotate;
        key_joy_1   = x.kjoy[0];
        key_joy_2   = x.kjoy[1];
        key_joy_3   = x.kjoy[2];
        key_coin    = x.kcoin;
        key_start   = x.kstart;
        key_pause   = x.kpause;
        key_reset   = x.kreset;
        key_service = x.kservice;
        key_gfx     = x.kgfx;
        osd_pause   = x.osd;
        downloading = x.dl;
    endtask

    // Edges are taken against the previous row
    task automatic update_model(input row_t x);
        logic joy_now;
        logic joy_old;
        logic flip;
        joy_now = x.joy[0][8] | x.joy[1][8];
        joy_old = prev.joy[0][8] | prev.joy[1][8];
        flip    = (x.kpause & ~prev.kpause) ^ (joy_now & ~joy_old) ^ x.osd;
        if (x.dl) exp_pause = 1'b0;
        else if (flip) exp_pause = ~exp_pause;
        exp_gfx     = exp_gfx ^ (x.kgfx & ~prev.kgfx);
        exp_service = ~x.kservice;
        if (x.kreset & ~prev.kreset) exp_resets++;
    endtask

    task automatic check_outputs(input row_t x);
        game_joy_t got [4];
        got[0] = game_joystick_1;
        got[1] = game_joystick_2;
        got[2] = game_joystick_3;
        got[3] = game_joystick_4;
        for (int p = 0; p < num_players; p++) begin
            check_joy($sformatf("game_joystick_%0d", p + 1), got[p], x.ejoy[p]);
        end
        check_vec("game_coin", game_coin, x.ecoin);
        check_vec("game_start", game_start, x.estart);
        check_bit("game_pause", game_pause, exp_pause);
        check_bit("game_service", game_service, exp_service);
        check_gfx("gfx_en", gfx_en, exp_gfx);
        check_count("soft_rst pulses", soft_count, exp_resets);
    endtask

    initial begin
        drive_inputs('0);
        prev = '0;
        build_table();
        timeout_limit = hold_total + 100;
        @(negedge rst);
        @(negedge clk_sys);
        clear_row();
        check_outputs(expected_of(r));      // Idle values
        check_bit("soft_rst", soft_rst, 1'b0);
        foreach (rows[i]) begin
            update_model(rows[i]);
            drive_inputs(rows[i]);
            @(negedge clk_sys);
            osd_pause = 1'b0;               // Single cycle pulse
            repeat (rows[i].hold - 1) @(negedge clk_sys);
            check_outputs(rows[i]);
            prev = rows[i];
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== src.f ====
source/board_pkg.sv
source/joy_4way_filter.sv
source/joy_capture.sv
source/game_input_map.sv
source/board_control.sv
source/board_inputs.sv
verification/tb_clock.sv
verification/board_inputs_tb.sv

// ==== Bender.yml ====
package:
  name: board_inputs

sources:
  - source/board_pkg.sv
  - source/joy_4way_filter.sv
  - source/joy_capture.sv
  - source/game_input_map.sv
  - source/board_control.sv
  - source/board_inputs.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/board_inputs_tb.sv
